// ==== files.f ====
+incdir+.
pet_pkg.sv
memory_control.sv
address_decoding.sv
access_pipeline.sv
pet_bus_decoder_top.sv
pet_bus_decoder_asserts.sv
pet_bus_decoder_tb.sv

// ==== Makefile ====
# Verilator build for the PET bus decoder testbench

VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= pet_bus_decoder_tb
RTL_TOP    ?= pet_bus_decoder_top
FILELIST   ?= files.f
LOG        ?= sim.log
PASS_MSG   := TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" \
		|| (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== pet_bus_decoder_stim.txt ====
# op addr data sel ram_addr we; op 0 read, 1 write, 2/3 read/write bus enable low, 4 idle
# op +8 issues the next line on the following clock; all fields hex
4 0003 00 000 00000 0
0 1234 00 001 01234 0
0 8000 00 201 08000 0
0 8F10 00 002 08F10 0
0 E805 00 004 0E805 0
0 E812 00 088 0E812 0
0 E825 00 090 0E825 0
0 E850 00 0A0 0E850 0
0 E890 00 040 0E890 0
0 C000 00 101 0C000 0
0 E900 00 101 0E900 0
0 FFFC 00 101 0FFFC 0
1 A000 55 101 0A000 0
1 0400 3C 001 00400 1
2 1234 00 000 01234 0
3 E810 11 000 0E810 0
3 FFF0 00 000 0FFF0 0
0 C000 00 101 0C000 0
# Expansion on, both banks select 1
1 FFF0 0C 101 0FFF0 0
0 9000 00 001 19000 0
1 9000 AA 001 19000 1
0 E810 00 001 1E810 0
0 8000 00 001 18000 0
# Low bank protected, both selects 0
1 FFF0 01 001 1FFF0 1
0 A000 00 101 12000 0
1 A000 55 101 12000 0
0 C123 00 001 14123 0
# Screen and IO peek-through
1 FFF0 60 001 17FF0 1
0 8000 00 201 08000 0
0 8F00 00 002 08F00 0
0 9000 00 001 11000 0
0 E840 00 0A0 0E840 0
0 E880 00 040 0E880 0
0 EC00 00 101 0EC00 0
0 F000 00 001 17000 0
# Back-to-back cycles
9 FFF0 08 001 17FF0 1
8 C000 00 001 1C000 0
8 8000 00 001 10000 0
0 0010 00 001 00010 0
9 FFF0 80 001 1FFF0 1
8 E810 00 088 0E810 0
0 8F00 00 002 08F00 0

// ==== pet_bus_decoder_tb.sv ====
// Needs pet_bus_decoder_stim.txt in the working directory; random traffic stays in $0000-$7FFF
`include "pet_defines.svh"

module pet_bus_decoder_tb import pet_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20;
    localparam int RANDOM_CYCLES  = 24;

    logic      sys_clock_i;
    logic      reset_i;
    logic      cpu_strobe_i;
    logic      cpu_be_i;
    logic      cpu_write_i;
    cpu_addr_t cpu_addr_i;
    cpu_data_t cpu_data_i;
    logic      access_strobe_o;
    logic      ram_en_o, sid_en_o, magic_en_o, pia1_en_o, pia2_en_o;
    logic      via_en_o, crtc_en_o, io_en_o, is_rom_o, is_vram_o;
    logic      ram_we_o;
    ram_addr_t ram_addr_o;

    chip_sel_t act_sel;         // Loose flags gathered back
    logic [31:0] lfsr_state;

    // Results still in flight
    chip_sel_t exp_sel_q[$];
    ram_addr_t exp_ram_q[$];
    logic      exp_we_q[$];
    string     name_q[$];

    pet_bus_decoder_top u_pet_bus_decoder_top (.*);

    always #5 sys_clock_i = ~sys_clock_i;

    always_comb begin
        act_sel                 = '0;
        act_sel[`PET_SEL_RAM]   = ram_en_o;
        act_sel[`PET_SEL_SID]   = sid_en_o;
        act_sel[`PET_SEL_MAGIC] = magic_en_o;
        act_sel[`PET_SEL_PIA1]  = pia1_en_o;
        act_sel[`PET_SEL_PIA2]  = pia2_en_o;
        act_sel[`PET_SEL_VIA]   = via_en_o;
        act_sel[`PET_SEL_CRTC]  = crtc_en_o;
        act_sel[`PET_SEL_IO]    = io_en_o;
        act_sel[`PET_SEL_ROM]   = is_rom_o;
        act_sel[`PET_SEL_VRAM]  = is_vram_o;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_sel(input string name, input chip_sel_t exp, input chip_sel_t act);
        if (exp !== act) begin
            fail_run($sformatf("Fail %s select: expected %03h, actual %03h", name, exp, act));
        end
    endtask

    task automatic check_ram_addr(input string name, input ram_addr_t exp, input ram_addr_t act);
        if (exp !== act) begin
            fail_run($sformatf("Fail %s ram_addr: expected %05h, actual %05h", name, exp, act));
        end
    endtask

    task automatic check_we(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("Fail %s ram_we: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    // Outputs are stable mid-cycle
    always @(negedge sys_clock_i) begin
        if (!reset_i && access_strobe_o) begin
            if (name_q.size() == 0) begin
                fail_run("An access strobe arrived with no cycle pending");
            end else begin
                check_sel(name_q[0], exp_sel_q.pop_front(), act_sel);
                check_ram_addr(name_q[0], exp_ram_q.pop_front(), ram_addr_o);
                check_we(name_q[0], exp_we_q.pop_front(), ram_we_o);
                void'(name_q.pop_front());
            end
        end
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return value;
    endfunction

    task automatic start_cycle(input logic be, input logic wr, input cpu_addr_t addr,
                               input cpu_data_t data);
        @(posedge sys_clock_i);
        #1;
        cpu_strobe_i = 1'b1;
        cpu_be_i     = be;
        cpu_write_i  = wr;
        cpu_addr_i   = addr;
        cpu_data_i   = data;
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge sys_clock_i);
            #1;
            cpu_strobe_i = 1'b0;
        end
    endtask

    task automatic wait_for_results();
        int waited;
        waited = 0;
        idle_cycles(1);
        while (name_q.size() != 0) begin
            @(posedge sys_clock_i);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                fail_run("Timeout: the access strobe never came");
            end
        end
    endtask

    task automatic expect_result(input string name, input chip_sel_t sel,
                                 input ram_addr_t ram, input logic we);
        exp_sel_q.push_back(sel);
        exp_ram_q.push_back(ram);
        exp_we_q.push_back(we);
        name_q.push_back(name);
    endtask

    task automatic run_stim_file();
        int          fd;
        int          line_no;
        int          fields;
        string       line;
        logic [3:0]  op;
        cpu_addr_t   addr;
        cpu_data_t   data;
        chip_sel_t   sel;
        ram_addr_t   ram;
        logic        we;
        fd      = $fopen("pet_bus_decoder_stim.txt", "r");
        line_no = 0;
        if (fd == 0) begin
            fail_run("Could not open pet_bus_decoder_stim.txt");
        end
        while (!$feof(fd)) begin
            line_no++;
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != 8'h23) begin
                fields = $sscanf(line, "%h %h %h %h %h %h", op, addr, data, sel, ram, we);
                if (fields == 6) begin
                    if (op[2:0] == 3'd4) begin
                        idle_cycles(int'(addr));
                    end else begin
                        start_cycle(!op[1], op[0], addr, data);
                        expect_result($sformatf("stim line %0d", line_no), sel, ram, we);
                        if (!op[3]) begin
                            wait_for_results();  // Bit 3 keeps the next cycle back-to-back
                        end
                    end
                end
            end
        end
        $fclose(fd);
        wait_for_results();
    endtask

    task automatic run_random_ram();
        logic [31:0] addr_bits;
        logic [31:0] wr_bit;
        logic [31:0] data_bits;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            addr_bits = rand_bits(15);
            wr_bit    = rand_bits(1);
            data_bits = rand_bits(8);
            start_cycle(1'b1, wr_bit[0], {1'b0, addr_bits[14:0]}, data_bits[7:0]);
            expect_result($sformatf("random %0d", i), chip_sel_t'(1) << `PET_SEL_RAM,
                          {2'b00, addr_bits[14:0]}, wr_bit[0]);
            wait_for_results();
        end
    endtask

    initial begin
        sys_clock_i  = 1'b0;
        reset_i      = 1'b1;
        cpu_strobe_i = 1'b0;
        cpu_be_i     = 1'b0;
        cpu_write_i  = 1'b0;
        cpu_addr_i   = '0;
        cpu_data_i   = '0;
        lfsr_state   = 32'hdd98;
        repeat (2) @(posedge sys_clock_i);
        #1;
        reset_i = 1'b0;

        run_stim_file();
        run_random_ram();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== pet_bus_decoder_asserts.sv ====
// Bound to pet_bus_decoder_top; checks hold only once reset has been seen for at least one edge
`include "pet_defines.svh"

module pet_bus_decoder_asserts import pet_pkg::*; (
    input logic      sys_clock_i,
    input logic      reset_i,
    input logic      cpu_strobe_i,
    input logic      access_strobe_o,
    input logic      ram_en_o,
    input logic      sid_en_o,
    input logic      magic_en_o,
    input logic      pia1_en_o,
    input logic      pia2_en_o,
    input logic      via_en_o,
    input logic      crtc_en_o,
    input logic      io_en_o,
    input logic      is_rom_o,
    input logic      is_vram_o,
    input logic      ram_we_o,
    input ram_addr_t ram_addr_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // Outputs settle to reset values one edge into reset
    reset_values: assert property (@(posedge sys_clock_i)
        reset_i && $past(reset_i) |-> !access_strobe_o && !ram_we_o && ram_addr_o == '0
            && {ram_en_o, sid_en_o, magic_en_o, pia1_en_o, pia2_en_o, via_en_o,
                crtc_en_o, io_en_o, is_rom_o, is_vram_o} == '0)
        else $error("outputs not at reset values during reset");

    one_device: assert property (@(posedge sys_clock_i) disable iff (reset_i)
        $onehot0({sid_en_o, magic_en_o, pia1_en_o, pia2_en_o, via_en_o, crtc_en_o}))
        else $error("more than one device select high");

    we_qualified: assert property (@(posedge sys_clock_i) disable iff (reset_i)
        ram_we_o |-> ram_en_o && !is_rom_o)
        else $error("ram_we_o without RAM select or with ROM flag");

    // Fixed two-edge latency
    strobe_latency: assert property (@(posedge sys_clock_i) disable iff (reset_i)
        access_strobe_o == $past(cpu_strobe_i, 2))
        else $error("access_strobe_o not two edges after cpu_strobe_i");

endmodule

bind pet_bus_decoder_top pet_bus_decoder_asserts u_pet_bus_decoder_asserts (.*);

// ==== pet_bus_decoder_top.sv ====
// Decoder only; peripherals, read data and video timing live outside, and the source must not expect stalls
`include "pet_defines.svh"

module pet_bus_decoder_top import pet_pkg::*; (
    input  logic      sys_clock_i,
    input  logic      reset_i,

    // Bus cycle, valid with the strobe
    input  logic      cpu_strobe_i,
    input  logic      cpu_be_i,
    input  logic      cpu_write_i,
    input  cpu_addr_t cpu_addr_i,
    input  cpu_data_t cpu_data_i,

    // Decoded access, two edges after the strobe
    output logic      access_strobe_o,
    output logic      ram_en_o,
    output logic      sid_en_o,
    output logic      magic_en_o,
    output logic      pia1_en_o,
    output logic      pia2_en_o,
    output logic      via_en_o,
    output logic      crtc_en_o,
    output logic      io_en_o,
    output logic      is_rom_o,
    output logic      is_vram_o,
    output logic      ram_we_o,
    output ram_addr_t ram_addr_o
);

    logic      s1_be;
    cpu_addr_t s1_addr;
    cpu_data_t s1_data;
    logic      mem_ctl_wr_strobe;
    chip_sel_t dec_sel;     // Combinational decode of stage 1
    logic      decoded_a15;
    logic      decoded_a16;
    chip_sel_t out_sel;     // Registered selects

    access_pipeline u_access_pipeline (
        .sys_clock_i         (sys_clock_i),
        .reset_i             (reset_i),
        .cpu_strobe_i        (cpu_strobe_i),
        .cpu_be_i            (cpu_be_i),
        .cpu_write_i         (cpu_write_i),
        .cpu_addr_i          (cpu_addr_i),
        .cpu_data_i          (cpu_data_i),
        .s1_be_o             (s1_be),
        .s1_addr_o           (s1_addr),
        .s1_data_o           (s1_data),
        .mem_ctl_wr_strobe_o (mem_ctl_wr_strobe),
        .sel_i               (dec_sel),
        .decoded_a15_i       (decoded_a15),
        .decoded_a16_i       (decoded_a16),
        .access_strobe_o     (access_strobe_o),
        .sel_o               (out_sel),
        .ram_we_o            (ram_we_o),
        .ram_addr_o          (ram_addr_o)
    );

    address_decoding u_address_decoding (
        .sys_clock_i         (sys_clock_i),
        .reset_i             (reset_i),
        .mem_ctl_wr_strobe_i (mem_ctl_wr_strobe),
        .cpu_be_i            (s1_be),
        .cpu_addr_i          (s1_addr),
        .cpu_data_i          (s1_data),
        .sel_o               (dec_sel),
        .decoded_a15_o       (decoded_a15),
        .decoded_a16_o       (decoded_a16)
    );

    // Fan out the select vector
    assign ram_en_o   = out_sel[`PET_SEL_RAM];
    assign sid_en_o   = out_sel[`PET_SEL_SID];
    assign magic_en_o = out_sel[`PET_SEL_MAGIC];
    assign pia1_en_o  = out_sel[`PET_SEL_PIA1];
    assign pia2_en_o  = out_sel[`PET_SEL_PIA2];
    assign via_en_o   = out_sel[`PET_SEL_VIA];
    assign crtc_en_o  = out_sel[`PET_SEL_CRTC];
    assign io_en_o    = out_sel[`PET_SEL_IO];
    assign is_rom_o   = out_sel[`PET_SEL_ROM];
    assign is_vram_o  = out_sel[`PET_SEL_VRAM];

endmodule

// ==== access_pipeline.sv ====
// No stall input; a strobe is accepted every clock and its results appear exactly two edges later
`include "pet_defines.svh"

module access_pipeline import pet_pkg::*; (
    input  logic      sys_clock_i,
    input  logic      reset_i,

    // Incoming bus cycle
    input  logic      cpu_strobe_i,
    input  logic      cpu_be_i,
    input  logic      cpu_write_i,
    input  cpu_addr_t cpu_addr_i,
    input  cpu_data_t cpu_data_i,

    // Stage 1 toward the decoder
    output logic      s1_be_o,
    output cpu_addr_t s1_addr_o,
    output cpu_data_t s1_data_o,
    output logic      mem_ctl_wr_strobe_o,

    // Decode of stage 1
    input  chip_sel_t sel_i,
    input  logic      decoded_a15_i,
    input  logic      decoded_a16_i,

    // Stage 2 results
    output logic      access_strobe_o,
    output chip_sel_t sel_o,
    output logic      ram_we_o,
    output ram_addr_t ram_addr_o
);

    logic s1_valid;
    logic s1_write;
    logic ram_write;

    // Stage 1
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= cpu_strobe_i;
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (cpu_strobe_i) begin
            s1_be_o   <= cpu_be_i;
            s1_write  <= cpu_write_i;
            s1_addr_o <= cpu_addr_i;
            s1_data_o <= cpu_data_i;
        end
    end

    // Register loads on the next edge, before this cycle's decode is used again
    assign mem_ctl_wr_strobe_o = s1_valid && s1_be_o && s1_write
                              && (s1_addr_o == `PET_MEM_CTL_ADDR);

    // Writes into ROM space are dropped
    assign ram_write = s1_write && sel_i[`PET_SEL_RAM] && !sel_i[`PET_SEL_ROM];

    // Stage 2, held until the next strobe
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            access_strobe_o <= 1'b0;
            sel_o           <= '0;
            ram_we_o        <= 1'b0;
            ram_addr_o      <= '0;
        end else begin
            access_strobe_o <= s1_valid;
            if (s1_valid) begin
                sel_o      <= sel_i;
                ram_we_o   <= ram_write;
                ram_addr_o <= {decoded_a16_i, decoded_a15_i, s1_addr_o[14:0]};
            end
        end
    end

endmodule

// ==== address_decoding.sv ====
// Purely combinational map decode apart from the bank register; selects are 0 whenever bus enable is low
`include "pet_defines.svh"

module address_decoding import pet_pkg::*; (
    input  logic      sys_clock_i,
    input  logic      reset_i,
    input  logic      mem_ctl_wr_strobe_i,  // Control register write
    input  logic      cpu_be_i,             // Bus enable of the cycle
    input  cpu_addr_t cpu_addr_i,
    input  cpu_data_t cpu_data_i,

    output chip_sel_t sel_o,                // Device selects and flags
    output logic      decoded_a15_o,        // A15 after banking
    output logic      decoded_a16_o         // Set for expansion RAM
);

    // Single-bit masks
    localparam chip_sel_t M_RAM   = chip_sel_t'(1) << `PET_SEL_RAM;
    localparam chip_sel_t M_SID   = chip_sel_t'(1) << `PET_SEL_SID;
    localparam chip_sel_t M_MAGIC = chip_sel_t'(1) << `PET_SEL_MAGIC;
    localparam chip_sel_t M_PIA1  = chip_sel_t'(1) << `PET_SEL_PIA1;
    localparam chip_sel_t M_PIA2  = chip_sel_t'(1) << `PET_SEL_PIA2;
    localparam chip_sel_t M_VIA   = chip_sel_t'(1) << `PET_SEL_VIA;
    localparam chip_sel_t M_CRTC  = chip_sel_t'(1) << `PET_SEL_CRTC;
    localparam chip_sel_t M_IO    = chip_sel_t'(1) << `PET_SEL_IO;
    localparam chip_sel_t M_ROM   = chip_sel_t'(1) << `PET_SEL_ROM;
    localparam chip_sel_t M_VRAM  = chip_sel_t'(1) << `PET_SEL_VRAM;

    // Combined decode results
    localparam chip_sel_t DEC_NONE = '0;
    localparam chip_sel_t DEC_ROM  = M_RAM | M_ROM;      // ROM image sits in RAM
    localparam chip_sel_t DEC_VRAM = M_RAM | M_VRAM;
    localparam chip_sel_t DEC_PIA1 = M_PIA1 | M_IO;
    localparam chip_sel_t DEC_PIA2 = M_PIA2 | M_IO;
    localparam chip_sel_t DEC_VIA  = M_VIA | M_IO;

    logic bank_en;
    logic bank_a15;
    logic bank_ro;

    memory_control u_memory_control (
        .sys_clock_i         (sys_clock_i),
        .reset_i             (reset_i),
        .mem_ctl_wr_strobe_i (mem_ctl_wr_strobe_i),
        .cpu_addr_i          (cpu_addr_i),
        .cpu_data_i          (cpu_data_i),
        .bank_en_o           (bank_en),
        .bank_a15_o          (bank_a15),
        .bank_ro_o           (bank_ro)
    );

    always_comb begin
        if (!cpu_be_i) begin
            sel_o = DEC_NONE;
        end else if (bank_en) begin
            sel_o = bank_ro ? DEC_ROM : M_RAM;          // Expansion RAM
        end else begin
            // First match wins, so SID shadows the top of screen memory
            priority casez (cpu_addr_i)
                16'b0???_????_????_????: sel_o = M_RAM;     // 0000-7FFF
                16'b1000_1111_????_????: sel_o = M_SID;     // 8F00-8FFF
                16'b1000_????_????_????: sel_o = DEC_VRAM;  // 8000-8FFF
                16'b1110_1000_0000_????: sel_o = M_MAGIC;   // E800-E80F
                16'b1110_1000_0001_????: sel_o = DEC_PIA1;  // E810-E81F
                16'b1110_1000_001?_????: sel_o = DEC_PIA2;  // E820-E83F
                16'b1110_1000_01??_????: sel_o = DEC_VIA;   // E840-E87F
                16'b1110_1000_1???_????: sel_o = M_CRTC;    // E880-E8FF, on-chip
                default:                 sel_o = DEC_ROM;   // Remaining ROM space
            endcase
        end
    end

    assign decoded_a15_o = bank_en ? bank_a15 : cpu_addr_i[15];
    assign decoded_a16_o = bank_en;

endmodule

// ==== memory_control.sv ====
// Control register is write-only here; the caller must qualify the write strobe with a write to $FFF0
`include "pet_defines.svh"

module memory_control import pet_pkg::*; (
    input  logic      sys_clock_i,
    input  logic      reset_i,
    input  logic      mem_ctl_wr_strobe_i,  // Qualified write to $FFF0
    input  cpu_addr_t cpu_addr_i,           // Address being decoded
    input  cpu_data_t cpu_data_i,           // New register value

    output logic      bank_en_o,            // Address falls in an active bank
    output logic      bank_a15_o,           // Bank bit replacing A15
    output logic      bank_ro_o             // Active bank is write protected
);

    mem_ctl_t mem_ctl;
    logic     expansion_on;
    logic     screen_hit;
    logic     io_hit;
    logic     screen_release;
    logic     io_release;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            mem_ctl <= `PET_MEM_CTL_RESET;
        end else if (mem_ctl_wr_strobe_i) begin
            mem_ctl <= cpu_data_i;
        end
    end

    assign expansion_on = !mem_ctl[`PET_MEM_CTL_DISABLE];

    // Peek-through windows
    assign screen_hit = (cpu_addr_i[15:12] == 4'b1000);    // $8000-$8FFF
    assign io_hit     = (cpu_addr_i[15:11] == 5'b11101);   // $E800-$EFFF

    assign screen_release = screen_hit && mem_ctl[`PET_MEM_CTL_SCREEN_PEEK];
    assign io_release     = io_hit && mem_ctl[`PET_MEM_CTL_IO_PEEK];

    // Bank decode for the upper 32 KB; the lower half is never banked
    always_comb begin
        bank_en_o  = 1'b0;
        bank_a15_o = 1'b0;
        bank_ro_o  = 1'b0;

        if (expansion_on && cpu_addr_i[15]) begin
            if (!cpu_addr_i[14]) begin
                // $8000-$BFFF, bank 0 or 1
                bank_en_o  = !screen_release;
                bank_a15_o = mem_ctl[`PET_MEM_CTL_SEL_LO];
                bank_ro_o  = mem_ctl[`PET_MEM_CTL_WP_LO];
            end else begin
                // $C000-$FFFF, bank 2 or 3
                bank_en_o  = !io_release;
                bank_a15_o = mem_ctl[`PET_MEM_CTL_SEL_HI];
                bank_ro_o  = mem_ctl[`PET_MEM_CTL_WP_HI];
            end

            // Released windows fall back to the PET map
            if (!bank_en_o) begin
                bank_a15_o = 1'b0;
                bank_ro_o  = 1'b0;
            end
        end
    end

endmodule

// ==== pet_pkg.sv ====
// Plain vector types only; widths come from pet_defines.svh, so change them there and nowhere else
`include "pet_defines.svh"

package pet_pkg;

    // CPU side of the bus
    typedef logic [`PET_ADDR_WIDTH-1:0] cpu_addr_t;     // 6502 address
    typedef logic [`PET_DATA_WIDTH-1:0] cpu_data_t;     // 6502 data

    // Banked RAM address, bit 16 set for expansion banks
    typedef logic [`PET_RAM_ADDR_WIDTH-1:0] ram_addr_t;

    // Contents of the $FFF0 register
    typedef logic [`PET_DATA_WIDTH-1:0] mem_ctl_t;

    // One-hot device selects plus the IO, ROM and VRAM flags,
    // indexed by the PET_SEL_* positions
    typedef logic [`PET_SEL_WIDTH-1:0] chip_sel_t;

endpackage

// ==== pet_defines.svh ====
// Widths, $FFF0 control-register layout and select bit order; select positions must match chip_sel_t users
`ifndef PET_DEFINES_SVH
`define PET_DEFINES_SVH

// Bus and RAM widths
`define PET_ADDR_WIDTH      16
`define PET_DATA_WIDTH      8
`define PET_RAM_ADDR_WIDTH  17      // 128 KB, base 64 KB plus expansion

// Memory-control register
`define PET_MEM_CTL_ADDR    16'hFFF0
`define PET_MEM_CTL_RESET   8'h80   // Expansion disabled

`define PET_MEM_CTL_WP_LO           0   // Write protect $8000-$BFFF
`define PET_MEM_CTL_WP_HI           1   // Write protect $C000-$FFFF
`define PET_MEM_CTL_SEL_LO          2   // Bank select $8000-$BFFF
`define PET_MEM_CTL_SEL_HI          3   // Bank select $C000-$FFFF
`define PET_MEM_CTL_IO_PEEK         5   // $E800-$EFFF back to IO
`define PET_MEM_CTL_SCREEN_PEEK     6   // $8000-$8FFF back to screen
`define PET_MEM_CTL_DISABLE         7   // Expansion off when set

// Select vector bit order
`define PET_SEL_RAM     0
`define PET_SEL_SID     1
`define PET_SEL_MAGIC   2
`define PET_SEL_PIA1    3
`define PET_SEL_PIA2    4
`define PET_SEL_VIA     5
`define PET_SEL_CRTC    6
`define PET_SEL_IO      7   // Device lives off the FPGA
`define PET_SEL_ROM     8
`define PET_SEL_VRAM    9

`define PET_SEL_WIDTH   10

`endif
